/* rtl/dig_regmap_pkg.sv */
// local bus geometry, register map and clock status encoding for the digitizer config
package dig_regmap_pkg;

	// local bus
	localparam int LB_AW = 12;   // word address
	localparam int LB_DW = 32;   // word data

	// idelay lanes, 8 per ADC chip
	localparam int IDELAY_W = 5;   // tap value
	localparam int IDELAY_N = 16;

	// word addresses seen by the host
	typedef enum logic [LB_AW-1:0] {
		REG_PERIPH_CONFIG  = 0,     // b0 pwr_en, b1 adc_pdwn, b2 mmcm_reset
		REG_BITSLIP        = 1,     // 8 bits per ADC
		REG_CLK_STATUS     = 2,     // write b0 freeze, b1 verify
		REG_SYNC_CSET      = 3,     // [9:0] ad7794, [21:16] tps62210
		REG_CAPTURE_CTRL   = 4,     // b0 trigger, [5:4] log2 block length
		REG_CAPTURE_STATUS = 5,     // run, done, pointer
		REG_IDELAY_BASE    = 16,    // 16 lanes, 16..31
		REG_CAPTURE_BASE   = 2048   // capture memory in upper half
	} reg_addr_e;

	// mmcm history as seen by software
	// unset after reset or any lock loss
	// frozen once software has set up the clocks
	// verified once the data path checked out
	typedef enum logic [1:0] {
		CLK_UNSET    = 2'd0,
		CLK_FROZEN   = 2'd1,
		CLK_VERIFIED = 2'd2
	} clk_status_e;

endpackage

/* rtl/capture_pkg.sv */
// sample format and sequencing states for the raw ADC capture
package capture_pkg;

	localparam int CHAN_N   = 8;    // two quad ADCs
	localparam int SAMPLE_W = 16;   // signed, two's complement

	// one-shot fill
	// idle until the first trigger, done once memory is full
	typedef enum logic [1:0] {
		CAP_IDLE = 2'd0,
		CAP_RUN  = 2'd1,
		CAP_DONE = 2'd2
	} capture_state_e;

endpackage

/* rtl/dig_regbank.sv */
// host register block, decodes bus writes into settings and strobes, registers read data
module dig_regbank import dig_regmap_pkg::*; #(
	parameter int cap_aw = 6
) (
	input  logic                   lb_clk,
	input  logic                   rst_n,
	input  logic                   lb_strobe,
	input  logic                   lb_rd,
	input  logic [LB_AW-1:0]       lb_addr,
	input  logic [LB_DW-1:0]       lb_dout,
	output logic [LB_DW-1:0]       lb_din,
	// settings
	output logic                   pwr_en,
	output logic                   adc_pdwn,
	output logic                   mmcm_reset,
	output logic [15:0]            bitslip,
	output logic [9:0]             ad7794_cset,
	output logic [5:0]             tps62210_cset,
	// clock status command
	output logic                   clk_status_we,
	output logic [1:0]             wr_data,
	// idelay write
	output logic                   idelay_we,
	output logic [$clog2(IDELAY_N)-1:0] idelay_idx,
	output logic [IDELAY_W-1:0]    idelay_data,
	// capture control
	output logic                   cap_trig,
	output logic [1:0]             cap_log_ratio,
	// read sources
	input  clk_status_e            clk_status,
	input  logic [IDELAY_W-1:0]    mirror_val,
	input  logic [LB_DW-1:0]       cap_status,
	output logic [$clog2(IDELAY_N)-1:0] rd_idx,
	output logic [cap_aw+1:0]      cap_rd_addr,
	input  logic [LB_DW-1:0]       cap_rd_data
);

	localparam int IDX_W = $clog2(IDELAY_N);

	logic wr_en, rd_en;
	logic in_idelay, in_capture;
	logic [LB_DW-1:0] rd_mux;

	assign wr_en = lb_strobe & ~lb_rd;
	assign rd_en = lb_strobe & lb_rd;

	// address windows
	assign in_idelay = (lb_addr >= REG_IDELAY_BASE) && (lb_addr < REG_IDELAY_BASE + IDELAY_N);
	assign in_capture = (lb_addr >= REG_CAPTURE_BASE);   // whole upper half, aliases above 2^(cap_aw+2)

	// write strobes act at the same edge as the bus write
	assign clk_status_we = wr_en && (lb_addr == REG_CLK_STATUS);
	assign wr_data = lb_dout[1:0];   // b0 freeze, b1 verify
	assign idelay_we = wr_en && in_idelay;
	assign idelay_idx = lb_addr[IDX_W-1:0];
	assign idelay_data = lb_dout[IDELAY_W-1:0];
	assign cap_trig = wr_en && (lb_addr == REG_CAPTURE_CTRL) && lb_dout[0];

	// readout addresses straight off the bus
	assign rd_idx = lb_addr[IDX_W-1:0];
	assign cap_rd_addr = lb_addr[cap_aw+1:0];   // word*4 + channel pair

	// settings registers
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			pwr_en        <= 1'b0;
			adc_pdwn      <= 1'b0;
			mmcm_reset    <= 1'b0;
			bitslip       <= '0;
			ad7794_cset   <= '0;
			tps62210_cset <= '0;
			cap_log_ratio <= '0;
		end else if (wr_en) begin
			case (lb_addr)
				REG_PERIPH_CONFIG: {mmcm_reset, adc_pdwn, pwr_en} <= lb_dout[2:0];
				REG_BITSLIP:       bitslip <= lb_dout[15:0];
				REG_SYNC_CSET: begin
					ad7794_cset   <= lb_dout[9:0];
					tps62210_cset <= lb_dout[21:16];
				end
				REG_CAPTURE_CTRL:  cap_log_ratio <= lb_dout[5:4];   // trigger bit not held
				default: ;
			endcase
		end
	end

	// read select, memory and mirror paths are combinational upstream
	always_comb begin
		rd_mux = '0;   // unmapped reads 0
		if (in_capture) begin
			rd_mux = cap_rd_data;
		end else if (in_idelay) begin
			rd_mux = LB_DW'(mirror_val);
		end else begin
			case (lb_addr)
				REG_PERIPH_CONFIG:  rd_mux = LB_DW'({mmcm_reset, adc_pdwn, pwr_en});
				REG_BITSLIP:        rd_mux = LB_DW'(bitslip);
				REG_CLK_STATUS:     rd_mux = LB_DW'(clk_status);
				REG_SYNC_CSET:      rd_mux = {10'b0, tps62210_cset, 6'b0, ad7794_cset};
				REG_CAPTURE_CTRL:   rd_mux = LB_DW'({cap_log_ratio, 4'b0});
				REG_CAPTURE_STATUS: rd_mux = cap_status;
				default:            rd_mux = '0;
			endcase
		end
	end

	// one cycle read latency everywhere, held until next read
	always_ff @(posedge lb_clk) begin
		if (!rst_n)
			lb_din <= '0;
		else if (rd_en)
			lb_din <= rd_mux;
	end

endmodule

/* rtl/clk_status_track.sv */
// mmcm status tracker, records clock setup progress and drops back on any lock loss
module clk_status_track import dig_regmap_pkg::*; (
	input  logic        lb_clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [1:0]  wr_data,       // b0 freeze, b1 verify
	input  logic        mmcm_locked,
	output clk_status_e clk_status
);

	clk_status_e status_nxt;

	always_comb begin
		status_nxt = clk_status;
		if (we) begin
			// verify only counts once frozen
			if (wr_data[1] && (clk_status == CLK_FROZEN))
				status_nxt = CLK_VERIFIED;
			else if (wr_data[0])
				status_nxt = CLK_FROZEN;
		end
		// lost lock beats any write
		if (!mmcm_locked)
			status_nxt = CLK_UNSET;
	end

	always_ff @(posedge lb_clk) begin
		if (!rst_n)
			clk_status <= CLK_UNSET;
		else
			clk_status <= status_nxt;
	end

endmodule

/* rtl/idelay_load_seq.sv */
// idelay load sequencer, turns lane writes into two-cycle load pulses and keeps readback mirrors
module idelay_load_seq import dig_regmap_pkg::*; (
	input  logic                        lb_clk,
	input  logic                        rst_n,
	input  logic                        we,
	input  logic [$clog2(IDELAY_N)-1:0] idx,
	input  logic [IDELAY_W-1:0]         data,
	input  logic [$clog2(IDELAY_N)-1:0] rd_idx,
	output logic [IDELAY_N-1:0]         idelay_ld,
	output logic [IDELAY_W-1:0]         idelay_value,
	output logic [IDELAY_W-1:0]         mirror_val
);

	localparam int IDX_W = $clog2(IDELAY_N);

	logic [1:0]          we_sr;      // write strobe history
	logic [IDX_W-1:0]    hold_idx;   // lane of last write
	logic [IDELAY_W-1:0] mirror [IDELAY_N];

	//   we         __-_______
	//   we_sr      ___--_____
	//   idelay_ld  ____--____  one lane only
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			we_sr        <= '0;
			hold_idx     <= '0;
			idelay_value <= '0;
			idelay_ld    <= '0;
			for (int n = 0; n < IDELAY_N; n++)
				mirror[n] <= '0;
		end else begin
			we_sr <= {we_sr[0], we};
			if (we) begin
				hold_idx     <= idx;
				idelay_value <= data;   // shared by all lanes
				mirror[idx]  <= data;
			end
			for (int n = 0; n < IDELAY_N; n++)
				idelay_ld[n] <= (|we_sr) && (hold_idx == IDX_W'(n));
		end
	end

	assign mirror_val = mirror[rd_idx];   // registered in regbank

endmodule

/* rtl/sync_pulse_gen.sv */
// sync clock for a switching regulator or converter, toggles once per programmable period
module sync_pulse_gen #(
	parameter int cw   = 10,
	parameter int minc = 256
) (
	input  logic          lb_clk,
	input  logic          rst_n,
	input  logic [cw-1:0] cset,
	output logic          sync
);

	localparam logic [cw-1:0] MINC = cw'(minc);

	logic [cw-1:0] cnt;
	logic [cw-1:0] reload;

	// floor keeps the target chip within its sync range
	assign reload = (cset > MINC) ? cset : MINC;

	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			cnt  <= MINC;   // first half period as after a slow reload
			sync <= 1'b0;
		end else if (cnt == '0) begin
			cnt  <= reload;   // new cset picked up here
			sync <= ~sync;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

endmodule

/* rtl/adc_capture.sv */
// raw ADC capture, block averages all channels and fills memory once per trigger
module adc_capture import dig_regmap_pkg::*; import capture_pkg::*; #(
	parameter int cap_aw = 6
) (
	input  logic                       lb_clk,
	input  logic                       rst_n,
	input  logic                       trig,
	input  logic [1:0]                 log_ratio,   // block of 2^k samples
	input  logic [CHAN_N*SAMPLE_W-1:0] adc_data,
	output logic [LB_DW-1:0]           status,
	input  logic [cap_aw+1:0]          rd_addr,
	output logic [LB_DW-1:0]           rd_data
);

	localparam int ACC_W = SAMPLE_W + 3;   // room for 8 samples
	localparam int WORD_W = CHAN_N * SAMPLE_W;

	capture_state_e state;
	logic [cap_aw-1:0] ptr;
	logic [2:0] cnt;        // sample within block
	logic [3:0] blk_len;
	logic blk_last;
	logic signed [ACC_W-1:0] acc [CHAN_N];
	logic signed [ACC_W-1:0] acc_sum [CHAN_N];
	logic signed [ACC_W-1:0] acc_avg [CHAN_N];
	logic [WORD_W-1:0] avg_word;
	logic [WORD_W-1:0] mem [2**cap_aw];
	logic [WORD_W-1:0] rd_word;

	assign blk_len = 4'd1 << log_ratio;
	assign blk_last = ({1'b0, cnt} == blk_len - 4'd1);

	// sum including current sample, then arithmetic shift, truncated
	always_comb begin
		for (int c = 0; c < CHAN_N; c++) begin
			acc_sum[c] = acc[c] + $signed(adc_data[c*SAMPLE_W +: SAMPLE_W]);
			acc_avg[c] = acc_sum[c] >>> log_ratio;
			avg_word[c*SAMPLE_W +: SAMPLE_W] = acc_avg[c][SAMPLE_W-1:0];
		end
	end

	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			state <= CAP_IDLE;
			ptr   <= '0;
			cnt   <= '0;
			for (int c = 0; c < CHAN_N; c++)
				acc[c] <= '0;
		end else if (trig) begin
			// restart, also when already running
			state <= CAP_RUN;
			ptr   <= '0;
			cnt   <= '0;
			for (int c = 0; c < CHAN_N; c++)
				acc[c] <= '0;
		end else if (state == CAP_RUN) begin
			if (blk_last) begin
				cnt <= '0;
				ptr <= ptr + 1'b1;   // wraps to 0 on the last store
				for (int c = 0; c < CHAN_N; c++)
					acc[c] <= '0;
				if (ptr == '1)
					state <= CAP_DONE;
			end else begin
				cnt <= cnt + 1'b1;
				for (int c = 0; c < CHAN_N; c++)
					acc[c] <= acc_sum[c];
			end
		end
	end

	// one averaged word per block
	always_ff @(posedge lb_clk) begin
		if ((state == CAP_RUN) && !trig && blk_last)
			mem[ptr] <= avg_word;
	end

	// host side, pair p gives {ch 2p+1, ch 2p}
	assign rd_word = mem[rd_addr[cap_aw+1:2]];
	assign rd_data = rd_word[rd_addr[1:0]*LB_DW +: LB_DW];

	assign status = {state == CAP_RUN, state == CAP_DONE, (LB_DW-2)'(ptr)};

endmodule

/* rtl/digitizer_config.sv */
// digitizer board configuration top, register block wired to clocking, idelay, sync and capture logic
module digitizer_config import dig_regmap_pkg::*; import capture_pkg::*; #(
	parameter int cap_aw = 6
) (
	input  logic                       lb_clk,
	input  logic                       rst_n,
	input  logic                       lb_strobe,
	input  logic                       lb_rd,
	input  logic [LB_AW-1:0]           lb_addr,
	input  logic [LB_DW-1:0]           lb_dout,
	output logic [LB_DW-1:0]           lb_din,
	input  logic                       mmcm_locked,
	input  logic [CHAN_N*SAMPLE_W-1:0] adc_data,
	output logic [IDELAY_N-1:0]        idelay_ld,
	output logic [IDELAY_W-1:0]        idelay_value,
	output logic                       pwr_en,
	output logic                       adc_pdwn,
	output logic                       mmcm_reset,
	output logic [15:0]                bitslip,
	output logic                       sync_ad7794,
	output logic                       sync_tps62210
);

	localparam int IDX_W = $clog2(IDELAY_N);

	logic [9:0] ad7794_cset;
	logic [5:0] tps62210_cset;
	logic clk_status_we;
	logic [1:0] wr_data;
	clk_status_e clk_status;
	logic idelay_we;
	logic [IDX_W-1:0] idelay_idx, rd_idx;
	logic [IDELAY_W-1:0] idelay_data, mirror_val;
	logic cap_trig;
	logic [1:0] cap_log_ratio;
	logic [LB_DW-1:0] cap_status, cap_rd_data;
	logic [cap_aw+1:0] cap_rd_addr;

	dig_regbank #(.cap_aw(cap_aw)) dig_regbank_inst (
		.lb_clk, .rst_n, .lb_strobe, .lb_rd, .lb_addr, .lb_dout, .lb_din,
		.pwr_en, .adc_pdwn, .mmcm_reset, .bitslip, .ad7794_cset, .tps62210_cset,
		.clk_status_we, .wr_data,
		.idelay_we, .idelay_idx, .idelay_data,
		.cap_trig, .cap_log_ratio,
		.clk_status, .mirror_val, .cap_status,
		.rd_idx, .cap_rd_addr, .cap_rd_data
	);

	clk_status_track clk_status_track_inst (
		.lb_clk, .rst_n, .we(clk_status_we), .wr_data, .mmcm_locked, .clk_status
	);

	idelay_load_seq idelay_load_seq_inst (
		.lb_clk, .rst_n, .we(idelay_we), .idx(idelay_idx), .data(idelay_data),
		.rd_idx, .idelay_ld, .idelay_value, .mirror_val
	);

	// ad7794 wants a slow clock, tps62210 a faster one
	sync_pulse_gen #(.cw(10), .minc(256)) sync_ad7794_inst (
		.lb_clk, .rst_n, .cset(ad7794_cset), .sync(sync_ad7794)
	);
	sync_pulse_gen #(.cw(6), .minc(32)) sync_tps62210_inst (
		.lb_clk, .rst_n, .cset(tps62210_cset), .sync(sync_tps62210)
	);

	adc_capture #(.cap_aw(cap_aw)) adc_capture_inst (
		.lb_clk, .rst_n, .trig(cap_trig), .log_ratio(cap_log_ratio), .adc_data,
		.status(cap_status), .rd_addr(cap_rd_addr), .rd_data(cap_rd_data)
	);

endmodule

/* bench/tb_digitizer_config.sv */
// testbench for the digitizer config top, random bus traffic checked against a bench model
module tb_digitizer_config import dig_regmap_pkg::*; import capture_pkg::*; ;

	localparam int CAP_AW = 6;
	localparam int WORDS = 2 ** CAP_AW;
	localparam logic [31:0] SEED = 32'h6725_d5d3;
	// worst case cycles per test
	localparam int T_REGS = 40 * 12;
	localparam int T_CLK = 40 * 8;
	localparam int T_IDELAY = 30 * 14 + 16 * 4;
	localparam int T_SYNC = 4 * (3 * 1024 + 16);
	localparam int T_CAP = 2 * (WORDS * 8 * 2 + WORDS * 4 * 3 + 64);
	localparam int CYCLE_LIMIT = T_REGS + T_CLK + T_IDELAY + T_SYNC + T_CAP + 1000;
	localparam int SYNC_GUARD = 3 * 1024;
	localparam int POLL_MAX = 64;

	logic lb_clk, rst_n, lb_strobe, lb_rd, mmcm_locked;
	logic [LB_AW-1:0] lb_addr;
	logic [LB_DW-1:0] lb_dout, lb_din;
	logic [CHAN_N*SAMPLE_W-1:0] adc_data;
	logic [IDELAY_N-1:0] idelay_ld;
	logic [IDELAY_W-1:0] idelay_value;
	logic pwr_en, adc_pdwn, mmcm_reset, sync_ad7794, sync_tps62210;
	logic [15:0] bitslip;

	// bench model
	logic [2:0] m_periph;
	logic [15:0] m_bitslip;
	clk_status_e m_status;
	logic [IDELAY_W-1:0] m_mirror [IDELAY_N];
	logic [CHAN_N*SAMPLE_W-1:0] cap_q [$];   // samples seen by the DUT after the last trigger
	logic [31:0] rng;
	int errors, cycles;

	digitizer_config #(.cap_aw(CAP_AW)) digitizer_config_inst (.*);

	always #4 lb_clk = ~lb_clk;

	always @(posedge lb_clk) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout, run went past %0d cycles", CYCLE_LIMIT);
			fail_stop();
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	task automatic fail_stop();
		$display("sim failed");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic check_word(input string name, input logic [LB_DW-1:0] exp_v, act);
		if (act !== exp_v) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp_v, act);
			fail_stop();
		end
	endtask

	task automatic check_status(input string name, input clk_status_e exp_v, act);
		if (act !== exp_v) begin
			errors++;
			$display("[ERROR] %s expected %s actual %s (%0d)", name, exp_v.name(), act.name(), act);
			fail_stop();
		end
	endtask

	task automatic check_ld(input string name, input logic [IDELAY_N-1:0] exp_v, act);
		if (act !== exp_v) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp_v, act);
			fail_stop();
		end
	endtask

	// returns just after the edge that takes the write
	task automatic bus_write(input logic [LB_AW-1:0] addr, input logic [LB_DW-1:0] data);
		@(posedge lb_clk);
		lb_strobe <= 1'b1;
		lb_rd     <= 1'b0;
		lb_addr   <= addr;
		lb_dout   <= data;
		@(posedge lb_clk);
		lb_strobe <= 1'b0;
	endtask

	task automatic bus_read(input logic [LB_AW-1:0] addr, output logic [LB_DW-1:0] data);
		@(posedge lb_clk);
		lb_strobe <= 1'b1;
		lb_rd     <= 1'b1;
		lb_addr   <= addr;
		@(posedge lb_clk);
		lb_strobe <= 1'b0;
		lb_rd     <= 1'b0;
		@(negedge lb_clk);
		data = lb_din;   // one cycle after the strobe
	endtask

	// clock status command with an optional one-cycle lock drop on the same edge
	task automatic clk_cmd(input logic do_wr, input logic [1:0] cmd, input logic drop);
		@(posedge lb_clk);
		lb_strobe   <= do_wr;
		lb_rd       <= 1'b0;
		lb_addr     <= LB_AW'(REG_CLK_STATUS);
		lb_dout     <= LB_DW'(cmd);
		mmcm_locked <= ~drop;
		@(posedge lb_clk);
		lb_strobe   <= 1'b0;
		mmcm_locked <= 1'b1;
	endtask

	// edges between the first two toggles seen after the call
	task automatic measure_sync(output int iv_ad, output int iv_tps);
		logic prev_ad, prev_tps;
		int n_ad, n_tps, guard;
		@(negedge lb_clk);
		prev_ad = sync_ad7794;
		prev_tps = sync_tps62210;
		n_ad = -1;
		n_tps = -1;
		iv_ad = 0;
		iv_tps = 0;
		guard = 0;
		while ((iv_ad == 0 || iv_tps == 0) && guard < SYNC_GUARD) begin
			@(negedge lb_clk);
			guard++;
			if (n_ad >= 0) n_ad++;
			if (n_tps >= 0) n_tps++;
			if (sync_ad7794 != prev_ad && iv_ad == 0) begin
				if (n_ad < 0) n_ad = 0;
				else iv_ad = n_ad;
			end
			if (sync_tps62210 != prev_tps && iv_tps == 0) begin
				if (n_tps < 0) n_tps = 0;
				else iv_tps = n_tps;
			end
			prev_ad = sync_ad7794;
			prev_tps = sync_tps62210;
		end
	endtask

	// called right after a rising edge so the next one takes the trigger
	task automatic trigger_capture(input logic [1:0] k);
		lb_strobe <= 1'b1;
		lb_rd     <= 1'b0;
		lb_addr   <= LB_AW'(REG_CAPTURE_CTRL);
		lb_dout   <= LB_DW'({k, 4'b0001});
		adc_data  <= {next_rand(), next_rand(), next_rand(), next_rand()};
		@(posedge lb_clk);
		lb_strobe <= 1'b0;
	endtask

	task automatic drive_samples(input int n, input logic rec);
		logic [CHAN_N*SAMPLE_W-1:0] s;
		repeat (n) begin
			s = {next_rand(), next_rand(), next_rand(), next_rand()};
			adc_data <= s;
			if (rec) cap_q.push_back(s);   // taken by the DUT at the next edge
			@(posedge lb_clk);
		end
	endtask

	// pre > 0 fires an early trigger and retriggers after pre samples
	task automatic run_capture(input logic [1:0] k, input int pre);
		cap_q.delete();
		@(posedge lb_clk);
		if (pre > 0) begin
			trigger_capture(k);
			drive_samples(pre, 1'b0);
		end
		trigger_capture(k);
		drive_samples(WORDS << k, 1'b1);
	endtask

	task automatic check_capture(input logic [1:0] k);
		logic [SAMPLE_W-1:0] avg [CHAN_N];
		logic [LB_DW-1:0] rd;
		int polls, sum, w, c, s, p;
		polls = 0;
		do begin
			bus_read(LB_AW'(REG_CAPTURE_STATUS), rd);
			polls++;
		end while (!rd[30] && polls < POLL_MAX);
		if (!rd[30]) begin
			$display("capture not done after %0d status polls", polls);
			fail_stop();
		end
		check_word("capture status", 32'h4000_0000, rd);   // done, pointer wrapped
		for (w = 0; w < WORDS; w++) begin
			for (c = 0; c < CHAN_N; c++) begin
				sum = 0;
				for (s = 0; s < (1 << k); s++)
					sum = sum + int'($signed(cap_q[(w << k) + s][c*SAMPLE_W +: SAMPLE_W]));
				avg[c] = SAMPLE_W'(sum >>> k);   // floor of the block mean
			end
			for (p = 0; p < CHAN_N / 2; p++) begin
				bus_read(LB_AW'(REG_CAPTURE_BASE + w * 4 + p), rd);
				check_word($sformatf("capture word %0d pair %0d", w, p),
					{avg[2*p+1], avg[2*p]}, rd);
			end
		end
	endtask

	initial begin : main
		int i, iv_ad, iv_tps, pre;
		logic [31:0] r, d, exp_w, rd;
		logic [LB_AW-1:0] addr;
		logic drop, do_wr;
		logic [1:0] cmd, k;
		logic [3:0] lane;
		logic [IDELAY_W-1:0] val;
		logic [IDELAY_N-1:0] mask;
		logic [9:0] c_ad;
		logic [5:0] c_tps;

		lb_clk = 1'b0;
		rst_n = 1'b0;
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		lb_addr = '0;
		lb_dout = '0;
		mmcm_locked = 1'b1;
		adc_data = '0;
		rng = SEED;
		errors = 0;
		cycles = 0;
		m_periph = '0;
		m_bitslip = '0;
		m_status = CLK_UNSET;
		for (i = 0; i < IDELAY_N; i++)
			m_mirror[i] = '0;
		repeat (4) @(posedge lb_clk);
		rst_n <= 1'b1;
		@(negedge lb_clk);
		check_word("outputs after reset", '0,
			LB_DW'({pwr_en, adc_pdwn, mmcm_reset, bitslip, sync_ad7794, sync_tps62210}));
		check_ld("idelay_ld after reset", '0, idelay_ld);
		bus_read(LB_AW'(REG_CLK_STATUS), rd);
		check_status("clock status after reset", CLK_UNSET, clk_status_e'(rd[1:0]));
		bus_read(LB_AW'(REG_CAPTURE_STATUS), rd);
		check_word("capture status after reset", '0, rd);   // idle, not running

		// settings registers plus reads of unmapped holes
		for (i = 0; i < 40; i++) begin
			r = next_rand();
			d = next_rand();
			case (r % 3)
				0: begin
					addr = REG_PERIPH_CONFIG;
					m_periph = d[2:0];
					exp_w = LB_DW'(d[2:0]);
				end
				1: begin
					addr = REG_BITSLIP;
					m_bitslip = d[15:0];
					exp_w = LB_DW'(d[15:0]);
				end
				default: begin
					addr = REG_SYNC_CSET;
					exp_w = d & 32'h003f_03ff;
				end
			endcase
			bus_write(addr, d);
			bus_read(addr, rd);
			check_word("settings readback", exp_w, rd);
			check_word("periph outputs", LB_DW'(m_periph), LB_DW'({mmcm_reset, adc_pdwn, pwr_en}));
			check_word("bitslip output", LB_DW'(m_bitslip), LB_DW'(bitslip));
			addr = r[8] ? LB_AW'(6 + r[15:12] % 10) : LB_AW'(32 + r[31:20] % 2016);
			bus_read(addr, rd);
			check_word("unmapped read", '0, rd);
		end

		// lock loss beats a clock status write on the same edge
		for (i = 0; i < 40; i++) begin
			r = next_rand();
			drop = (r[2:0] == 3'd0);
			do_wr = r[3] | r[4];
			cmd = r[6:5];
			clk_cmd(do_wr, cmd, drop);
			if (drop) m_status = CLK_UNSET;
			else if (do_wr && cmd[1] && m_status == CLK_FROZEN) m_status = CLK_VERIFIED;
			else if (do_wr && cmd[0]) m_status = CLK_FROZEN;
			bus_read(LB_AW'(REG_CLK_STATUS), rd);
			check_status("clock status", m_status, clk_status_e'(rd[1:0]));
		end

		// one lane pulses for the second and third edge after each idelay write
		for (i = 0; i < 30; i++) begin
			r = next_rand();
			lane = r[3:0];
			val = r[8:4];
			m_mirror[lane] = val;
			mask = IDELAY_N'(1) << lane;
			bus_write(LB_AW'(REG_IDELAY_BASE + lane), LB_DW'(val));
			@(negedge lb_clk);
			check_ld("idelay_ld before pulse", '0, idelay_ld);
			check_word("idelay_value", LB_DW'(val), LB_DW'(idelay_value));
			@(negedge lb_clk);
			check_ld("idelay_ld first cycle", mask, idelay_ld);
			@(negedge lb_clk);
			check_ld("idelay_ld second cycle", mask, idelay_ld);
			@(negedge lb_clk);
			check_ld("idelay_ld after pulse", '0, idelay_ld);
			bus_read(LB_AW'(REG_IDELAY_BASE + lane), rd);
			check_word("idelay mirror", LB_DW'(val), rd);
		end
		for (i = 0; i < IDELAY_N; i++) begin
			bus_read(LB_AW'(REG_IDELAY_BASE + i), rd);
			check_word($sformatf("idelay mirror lane %0d", i), LB_DW'(m_mirror[i]), rd);
		end

		// sync periods with the first pass below both floors
		for (i = 0; i < 4; i++) begin
			r = next_rand();
			c_ad = (i == 0) ? 10'(r[9:0] % 256) : r[9:0];
			c_tps = (i == 0) ? 6'(r[21:16] % 32) : r[21:16];
			bus_write(LB_AW'(REG_SYNC_CSET), {10'b0, c_tps, 6'b0, c_ad});
			measure_sync(iv_ad, iv_tps);
			check_word("ad7794 sync interval", LB_DW'((c_ad > 256 ? int'(c_ad) : 256) + 1),
				LB_DW'(iv_ad));
			check_word("tps62210 sync interval", LB_DW'((c_tps > 32 ? int'(c_tps) : 32) + 1),
				LB_DW'(iv_tps));
		end

		// single capture, then a retrigger part way through
		k = next_rand() % 4;
		run_capture(k, 0);
		bus_read(LB_AW'(REG_CAPTURE_CTRL), rd);
		check_word("capture ctrl readback", LB_DW'({k, 4'b0}), rd);
		check_capture(k);
		k = next_rand() % 4;
		pre = 1 + int'(next_rand() % ((WORDS << k) / 2));
		run_capture(k, pre);
		check_capture(k);

		if (errors == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			fail_stop();
		end
	end

endmodule

/* build.f */
rtl/dig_regmap_pkg.sv
rtl/capture_pkg.sv
rtl/dig_regbank.sv
rtl/clk_status_track.sv
rtl/idelay_load_seq.sv
rtl/sync_pulse_gen.sv
rtl/adc_capture.sv
rtl/digitizer_config.sv
bench/tb_digitizer_config.sv

/* Bender.yml */
package:
  name: digitizer_config

sources:
  - files:
      - rtl/dig_regmap_pkg.sv
      - rtl/capture_pkg.sv
      - rtl/dig_regbank.sv
      - rtl/clk_status_track.sv
      - rtl/idelay_load_seq.sv
      - rtl/sync_pulse_gen.sv
      - rtl/adc_capture.sv
      - rtl/digitizer_config.sv
  - target: simulation
    files:
      - bench/tb_digitizer_config.sv
